// File: rtl/coreConfig.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`default_nettype none

// Host word layout
`define CORE_PC_WIDTH 32
`define CORE_PC_CODE_WIDTH 8
`define CORE_CONF_ADDR_WIDTH 8
`define CORE_CONF_VALUE_WIDTH 16

// Chip word layout
`define CORE_BD_WIDTH 21
`define CORE_TAG_WIDTH 11
`define CORE_CT_WIDTH 9

// Generator array sizing
`define CORE_NUM_GENS 4
`define CORE_GEN_IDX_WIDTH 2
`define CORE_UNIT_WIDTH 16
`define CORE_PERIOD_WIDTH 16

// Register map
`define CORE_ADDR_UNIT 0
`define CORE_ADDR_ENABLE 1
`define CORE_ADDR_PERIOD 2
`define CORE_ADDR_TAG 6

`default_nettype wire

`endif

// File: rtl/pcWordPkg.sv
`include "coreConfig.svh"

`default_nettype none

package pcWordPkg;

  // Raw word from the host
  typedef logic [`CORE_PC_WIDTH-1:0] pcWord;

  // Top byte of a host word
  typedef enum logic [`CORE_PC_CODE_WIDTH-1:0] {
    codeConfWrite = 8'd1,
    codePass      = 8'd2
  } pcCode;

  // Fields of a configuration write
  typedef logic [`CORE_CONF_ADDR_WIDTH-1:0] confAddr;
  typedef logic [`CORE_CONF_VALUE_WIDTH-1:0] confValue;

  // Configuration register contents
  typedef logic [`CORE_UNIT_WIDTH-1:0] unitLen;
  typedef logic [`CORE_PERIOD_WIDTH-1:0] genPeriod;
  typedef logic [`CORE_NUM_GENS-1:0] genMask;
  typedef logic [`CORE_GEN_IDX_WIDTH-1:0] genIdx;

endpackage

`default_nettype wire

// File: rtl/bdWordPkg.sv
`include "coreConfig.svh"

`default_nettype none

package bdWordPkg;

  // Encoded word toward the chip
  typedef logic [`CORE_BD_WIDTH-1:0] bdWord;

  // Spike item fields
  typedef logic [`CORE_TAG_WIDTH-1:0] spikeTag;
  typedef logic [`CORE_CT_WIDTH-1:0] spikeCount;

  // Passthrough data, one bit narrower than a BD word
  // Top bit is the route bit
  typedef logic [`CORE_BD_WIDTH-2:0] passPayload;

  // Last source granted by the merge
  typedef enum logic {
    srcPass,
    srcSpike
  } mergeSource;

endpackage

`default_nettype wire

// File: rtl/coreIfs.sv
`include "coreConfig.svh"

`default_nettype none

// Generator configuration, static between writes
interface genConfIf import pcWordPkg::*, bdWordPkg::*; ();
  unitLen unitLength;
  genMask enable;
  genPeriod [`CORE_NUM_GENS-1:0] period;
  spikeTag [`CORE_NUM_GENS-1:0] tag;
  // One cycle high after a unit length write
  logic unitRestart;

  modport source (output unitLength, enable, period, tag, unitRestart);
  modport sink (input unitLength, enable, period, tag, unitRestart);
endinterface

// Tag and count channel, valid/ready
interface spikeTagIf import bdWordPkg::*; ();
  spikeTag tag;
  spikeCount ct;
  logic valid;
  logic ready;

  modport producer (output tag, ct, valid, input ready);
  modport consumer (input tag, ct, valid, output ready);
endinterface

`default_nettype wire

// File: rtl/pcParser.sv
`include "coreConfig.svh"

`default_nettype none

module pcParser import pcWordPkg::*, bdWordPkg::*; (
  input  wire logic       clk,
  input  wire logic       reset,
  // Host words
  input  wire pcWord      pcIn,
  input  wire logic       pcInValid,
  output      logic       pcInReady,
  // Passthrough toward the merge
  output      passPayload passData,
  output      logic       passValid,
  input  wire logic       passReady,
  // Generator registers
  genConfIf.source        conf
);

  logic accept;
  pcCode code;
  confAddr addr;
  confValue value;

  ////////////////////
  // Decode

  // Buffer empty or draining this cycle
  assign pcInReady = !passValid || passReady;
  assign accept = pcInValid && pcInReady;

  // Split the accepted word
  assign code = pcCode'(pcIn[`CORE_PC_WIDTH-1 -: `CORE_PC_CODE_WIDTH]);
  assign addr = pcIn[`CORE_CONF_VALUE_WIDTH +: `CORE_CONF_ADDR_WIDTH];
  assign value = pcIn[`CORE_CONF_VALUE_WIDTH-1:0];

  ////////////////////
  // Passthrough buffer

  // Single entry, refilled in the cycle it drains
  always_ff @(posedge clk) begin
    if (reset) begin
      passValid <= 1'b0;
    end else if (accept && code == codePass) begin
      passValid <= 1'b1;
    end else if (passReady) begin
      passValid <= 1'b0;
    end
  end

  // Low data bits only
  always_ff @(posedge clk) begin
    if (accept && code == codePass) begin
      passData <= pcIn[$bits(passPayload)-1:0];
    end
  end

  ////////////////////
  // Config registers

  always_ff @(posedge clk) begin
    if (reset) begin
      conf.unitLength <= '0;
      conf.enable <= '0;
      conf.period <= '0;
      conf.tag <= '0;
      conf.unitRestart <= 1'b0;
    end else begin
      conf.unitRestart <= 1'b0;
      if (accept && code == codeConfWrite) begin
        if (addr == confAddr'(`CORE_ADDR_UNIT)) begin
          conf.unitLength <= value;
          // Time base restarts on every length write
          conf.unitRestart <= 1'b1;
        end
        if (addr == confAddr'(`CORE_ADDR_ENABLE)) begin
          conf.enable <= value[`CORE_NUM_GENS-1:0];
        end
        // One period and one tag slot per generator
        for (int g = 0; g < `CORE_NUM_GENS; g++) begin
          if (addr == confAddr'(`CORE_ADDR_PERIOD + g)) begin
            conf.period[g] <= value;
          end
          if (addr == confAddr'(`CORE_ADDR_TAG + g)) begin
            conf.tag[g] <= value[`CORE_TAG_WIDTH-1:0];
          end
        end
      end
      // Unmapped addresses and junk codes fall through
    end
  end

  // Stalled passthrough word must not change
  passHold: assert property (@(posedge clk) disable iff (reset)
    passValid && !passReady |=> passValid && $stable(passData));

endmodule

`default_nettype wire

// File: rtl/spikeGenArray.sv
`include "coreConfig.svh"

`default_nettype none

module spikeGenArray import pcWordPkg::*, bdWordPkg::*; (
  input wire logic clk,
  input wire logic reset,
  genConfIf.sink   conf,
  spikeTagIf.producer spikes
);

  unitLen unitCount;
  logic unitPulse;
  genPeriod phase [`CORE_NUM_GENS];
  genMask fire;
  spikeCount pend [`CORE_NUM_GENS];
  spikeCount pendNext [`CORE_NUM_GENS];
  genIdx lastIdx;
  genIdx pick;
  logic found;
  logic load;

  ////////////////////
  // Time base

  // Zero length stops it, restart cycle never pulses
  assign unitPulse = !conf.unitRestart && (conf.unitLength != '0) &&
                     (unitCount == conf.unitLength - 1'b1);

  always_ff @(posedge clk) begin
    if (reset || conf.unitRestart || unitPulse) begin
      unitCount <= '0;
    end else if (conf.unitLength != '0) begin
      unitCount <= unitCount + 1'b1;
    end
  end

  ////////////////////
  // Period generators

  // Fire on the last phase of the period
  // >= covers a period shrunk below the current phase
  always_comb begin
    for (int g = 0; g < `CORE_NUM_GENS; g++) begin
      fire[g] = unitPulse && conf.enable[g] && (conf.period[g] != '0) &&
                (phase[g] >= conf.period[g] - 1'b1);
    end
  end

  // Disabled generators restart from phase 0
  always_ff @(posedge clk) begin
    for (int g = 0; g < `CORE_NUM_GENS; g++) begin
      if (reset || !conf.enable[g] || fire[g]) begin
        phase[g] <= '0;
      end else if (unitPulse && conf.period[g] != '0) begin
        phase[g] <= phase[g] + 1'b1;
      end
    end
  end

  ////////////////////
  // Pending counts

  // Round robin, first pending after the last served
  always_comb begin
    pick = lastIdx;
    found = 1'b0;
    for (int k = 1; k <= `CORE_NUM_GENS; k++) begin
      if (!found && pend[(int'(lastIdx) + k) % `CORE_NUM_GENS] != '0) begin
        found = 1'b1;
        pick = genIdx'((int'(lastIdx) + k) % `CORE_NUM_GENS);
      end
    end
  end

  // Offer register free or handing off
  assign load = found && (!spikes.valid || spikes.ready);

  // Clear on load, then count new firing, saturate at max
  always_comb begin
    for (int g = 0; g < `CORE_NUM_GENS; g++) begin
      pendNext[g] = pend[g];
      if (load && pick == genIdx'(g)) begin
        pendNext[g] = '0;
      end
      if (fire[g] && pendNext[g] != '1) begin
        pendNext[g] = pendNext[g] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int g = 0; g < `CORE_NUM_GENS; g++) begin
      if (reset) begin
        pend[g] <= '0;
      end else begin
        pend[g] <= pendNext[g];
      end
    end
  end

  ////////////////////
  // Offer register

  always_ff @(posedge clk) begin
    if (reset) begin
      spikes.valid <= 1'b0;
      lastIdx <= '0;
    end else if (load) begin
      spikes.valid <= 1'b1;
      lastIdx <= pick;
    end else if (spikes.ready) begin
      spikes.valid <= 1'b0;
    end
  end

  // Tag sampled when the count moves out
  always_ff @(posedge clk) begin
    if (load) begin
      spikes.tag <= conf.tag[pick];
      spikes.ct <= pend[pick];
    end
  end

  // Only nonzero counts reach the merge
  ctNonZero: assert property (@(posedge clk) disable iff (reset)
    spikes.valid |-> spikes.ct != '0);

  // Offered item frozen under back-pressure
  offerHold: assert property (@(posedge clk) disable iff (reset)
    spikes.valid && !spikes.ready |=>
      spikes.valid && $stable(spikes.tag) && $stable(spikes.ct));

endmodule

`default_nettype wire

// File: rtl/bdTagMerge.sv
`default_nettype none

module bdTagMerge import bdWordPkg::*; (
  input  wire logic       clk,
  input  wire logic       reset,
  // Passthrough from the parser
  input  wire passPayload passData,
  input  wire logic       passValid,
  output      logic       passReady,
  // Spike items from the generators
  spikeTagIf.consumer     spikes,
  // Encoded chip words
  output      bdWord      bdOut,
  output      logic       bdOutValid,
  input  wire logic       bdOutReady
);

  mergeSource lastSrc;
  logic outFree;
  logic takePass;
  logic takeSpike;

  ////////////////////
  // Arbitration

  // Output register empty or transferring
  assign outFree = !bdOutValid || bdOutReady;

  // Alternate when both sides wait
  always_comb begin
    takePass = 1'b0;
    takeSpike = 1'b0;
    if (outFree) begin
      if (passValid && spikes.valid) begin
        if (lastSrc == srcPass) begin
          takeSpike = 1'b1;
        end else begin
          takePass = 1'b1;
        end
      end else begin
        takePass = passValid;
        takeSpike = spikes.valid;
      end
    end
  end

  assign passReady = takePass;
  assign spikes.ready = takeSpike;

  ////////////////////
  // Output register

  // Reset grant points at spikes so passthrough wins the first tie
  always_ff @(posedge clk) begin
    if (reset) begin
      bdOutValid <= 1'b0;
      lastSrc <= srcSpike;
    end else begin
      if (takePass || takeSpike) begin
        bdOutValid <= 1'b1;
      end else if (bdOutReady) begin
        bdOutValid <= 1'b0;
      end
      if (takePass) begin
        lastSrc <= srcPass;
      end else if (takeSpike) begin
        lastSrc <= srcSpike;
      end
    end
  end

  // Route bit on top, 0 for passthrough and 1 for spikes
  always_ff @(posedge clk) begin
    if (takePass) begin
      bdOut <= {1'b0, passData};
    end else if (takeSpike) begin
      bdOut <= {1'b1, spikes.tag, spikes.ct};
    end
  end

  // Stalled word must not change
  outHold: assert property (@(posedge clk) disable iff (reset)
    bdOutValid && !bdOutReady |=> bdOutValid && $stable(bdOut));

endmodule

`default_nettype wire

// File: rtl/spikeCore.sv
`default_nettype none

module spikeCore import pcWordPkg::*, bdWordPkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  // Host side
  input  wire pcWord pcIn,
  input  wire logic  pcInValid,
  output      logic  pcInReady,
  // Chip side
  output      bdWord bdOut,
  output      logic  bdOutValid,
  input  wire logic  bdOutReady
);

  // Passthrough link, parser to merge
  passPayload passData;
  logic passValid;
  logic passReady;

  genConfIf genConf ();
  spikeTagIf spikeTags ();

  ////////////////////
  // Input side

  pcParser parser (
    .clk       (clk),
    .reset     (reset),
    .pcIn      (pcIn),
    .pcInValid (pcInValid),
    .pcInReady (pcInReady),
    .passData  (passData),
    .passValid (passValid),
    .passReady (passReady),
    .conf      (genConf.source)
  );

  ////////////////////
  // Spike generation

  spikeGenArray genArray (
    .clk    (clk),
    .reset  (reset),
    .conf   (genConf.sink),
    .spikes (spikeTags.producer)
  );

  ////////////////////
  // Output side

  bdTagMerge merge (
    .clk        (clk),
    .reset      (reset),
    .passData   (passData),
    .passValid  (passValid),
    .passReady  (passReady),
    .spikes     (spikeTags.consumer),
    .bdOut      (bdOut),
    .bdOutValid (bdOutValid),
    .bdOutReady (bdOutReady)
  );

endmodule

`default_nettype wire

// File: dv/spikeCoreChecker.sv
`include "coreConfig.svh"

`default_nettype none

module spikeCoreChecker import pcWordPkg::*, bdWordPkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire pcWord pcIn,
  input  wire logic  pcInValid,
  input  wire logic  pcInReady,
  input  wire bdWord bdOut,
  input  wire logic  bdOutValid,
  input  wire logic  bdOutReady,
  // Latency test window, nothing else in flight
  input  wire logic  isolated,
  input  wire logic  runDone,
  output int         mismatches,
  output int         otherErrors,
  output logic       checked
);
  timeunit 1ns;
  timeprecision 100ps;

  // Model registers as seen after the last edge
  int unitLength;
  int ticks;
  logic restart;
  genMask enable;
  int period [`CORE_NUM_GENS];
  int phase [`CORE_NUM_GENS];
  spikeTag tagOf [`CORE_NUM_GENS];
  // Firings in the model, counts seen on the output
  int fired [`CORE_NUM_GENS];
  int got [`CORE_NUM_GENS];
  passPayload expectPass [$];
  logic wasStalled;
  logic wasReset;
  bdWord stalledWord;
  int sampleIdx;
  int latStart;
  logic latPending;

  initial begin
    mismatches = 0;
    otherErrors = 0;
    checked = 1'b0;
    sampleIdx = 0;
    for (int g = 0; g < `CORE_NUM_GENS; g++) begin
      fired[g] = 0;
      got[g] = 0;
    end
  end

  function automatic int genOfTag(input spikeTag t);
    for (int g = 0; g < `CORE_NUM_GENS; g++) begin
      if (tagOf[g] == t) begin
        return g;
      end
    end
    return -1;
  endfunction

  task automatic resetModel();
    unitLength = 0;
    ticks = 0;
    restart = 1'b0;
    enable = '0;
    for (int g = 0; g < `CORE_NUM_GENS; g++) begin
      period[g] = 0;
      phase[g] = 0;
      tagOf[g] = '0;
    end
    wasStalled = 1'b0;
    latPending = 1'b0;
    wasReset = 1'b1;
  endtask

  ////////////////////
  // Output monitor

  task automatic checkOutput();
    int g;
    spikeTag tag;
    spikeCount ct;
    passPayload want;
    // A stalled word stays put
    if (wasStalled && !bdOutValid) begin
      $display("mismatch at %0t: bdOutValid expected 1 got 0", $time);
      mismatches++;
    end else if (wasStalled && bdOut !== stalledWord) begin
      $display("mismatch at %0t: bdOut expected %h got %h", $time, stalledWord, bdOut);
      mismatches++;
    end
    wasStalled = bdOutValid && !bdOutReady;
    stalledWord = bdOut;
    if (bdOutValid && latPending) begin
      if (sampleIdx - latStart != 2) begin
        $display("passthrough latency was %0d cycles instead of 2", sampleIdx - latStart);
        otherErrors++;
      end
      latPending = 1'b0;
    end
    if (!(bdOutValid && bdOutReady)) begin
      return;
    end
    if (!bdOut[`CORE_BD_WIDTH-1]) begin
      if (expectPass.size() == 0) begin
        $display("passthrough word %h came out with none sent", bdOut);
        otherErrors++;
        return;
      end
      want = expectPass.pop_front();
      if (bdOut[`CORE_BD_WIDTH-2:0] !== want) begin
        $display("mismatch at %0t: bdOut expected %h got %h", $time, {1'b0, want}, bdOut);
        mismatches++;
      end
      return;
    end
    tag = bdOut[`CORE_CT_WIDTH +: `CORE_TAG_WIDTH];
    ct = bdOut[`CORE_CT_WIDTH-1:0];
    g = genOfTag(tag);
    if (g < 0 || ct == 0) begin
      $display("spike word %h has an unknown tag or a zero count", bdOut);
      otherErrors++;
      return;
    end
    got[g] += ct;
    // Never more than the generator has fired so far
    if (got[g] > fired[g]) begin
      $display("mismatch at %0t: spike total of tag %h expected at most %0d got %0d",
               $time, tag, fired[g], got[g]);
      mismatches++;
    end
  endtask

  ////////////////////
  // Reference model

  task automatic stepModel();
    logic pulse;
    pcCode code;
    confAddr addr;
    confValue value;
    // Time base, clocks since the last restart
    pulse = 1'b0;
    if (restart) begin
      ticks = 0;
    end else if (unitLength != 0) begin
      ticks++;
      if (ticks == unitLength) begin
        pulse = 1'b1;
        ticks = 0;
      end
    end
    // Phase per generator, fires when it reaches the period
    for (int g = 0; g < `CORE_NUM_GENS; g++) begin
      if (!enable[g]) begin
        phase[g] = 0;
      end else if (pulse && period[g] != 0) begin
        phase[g]++;
        if (phase[g] >= period[g]) begin
          phase[g] = 0;
          fired[g]++;
        end
      end
    end
    restart = 1'b0;
    if (!(pcInValid && pcInReady)) begin
      return;
    end
    code = pcCode'(pcIn[`CORE_PC_WIDTH-1 -: `CORE_PC_CODE_WIDTH]);
    addr = pcIn[`CORE_CONF_VALUE_WIDTH +: `CORE_CONF_ADDR_WIDTH];
    value = pcIn[`CORE_CONF_VALUE_WIDTH-1:0];
    if (code == codePass) begin
      // Everything below the route bit of a BD word
      expectPass.push_back(pcIn[`CORE_BD_WIDTH-2:0]);
      if (isolated) begin
        latPending = 1'b1;
        latStart = sampleIdx;
      end
    end else if (code == codeConfWrite) begin
      if (addr == `CORE_ADDR_UNIT) begin
        unitLength = value;
        restart = 1'b1;
      end else if (addr == `CORE_ADDR_ENABLE) begin
        enable = value[`CORE_NUM_GENS-1:0];
      end else if (addr >= `CORE_ADDR_PERIOD && addr < `CORE_ADDR_PERIOD + `CORE_NUM_GENS) begin
        period[addr - `CORE_ADDR_PERIOD] = value;
      end else if (addr >= `CORE_ADDR_TAG && addr < `CORE_ADDR_TAG + `CORE_NUM_GENS) begin
        tagOf[addr - `CORE_ADDR_TAG] = value[`CORE_TAG_WIDTH-1:0];
      end
    end
  endtask

  // Sampled mid cycle, stands for the coming rising edge
  always @(negedge clk) begin
    sampleIdx++;
    if (reset) begin
      resetModel();
    end else begin
      if (wasReset && (!pcInReady || bdOutValid)) begin
        $display("ready or valid wrong right after reset");
        otherErrors++;
      end
      wasReset = 1'b0;
      checkOutput();
      stepModel();
    end
  end

  // End of run totals
  always @(posedge runDone) begin
    if (expectPass.size() != 0) begin
      $display("%0d passthrough words never came out", expectPass.size());
      otherErrors++;
    end
    for (int g = 0; g < `CORE_NUM_GENS; g++) begin
      if (got[g] != fired[g]) begin
        $display("mismatch at %0t: spike total of tag %h expected %0d got %0d",
                 $time, tagOf[g], fired[g], got[g]);
        mismatches++;
      end
    end
    checked = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/spikeCoreTb.sv
`include "coreConfig.svh"

`default_nettype none

module spikeCoreTb import pcWordPkg::*, bdWordPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int numWords = 200;
  // Latency word, tags, periods, unit, enable, final disable
  localparam int setupWords = 12;
  localparam int drainCycles = 300;
  localparam int cycleLimit = (numWords + setupWords) * 10 + drainCycles + 200;

  logic clk;
  logic reset;
  pcWord pcIn;
  logic pcInValid;
  logic pcInReady;
  bdWord bdOut;
  logic bdOutValid;
  logic bdOutReady;
  logic nextReady;
  logic holdReady;
  logic isolated;
  logic runDone;
  logic checked;
  int mismatches;
  int otherErrors;
  int cycles;
  integer seed = 58225;

  spikeCore uut (
    .clk        (clk),
    .reset      (reset),
    .pcIn       (pcIn),
    .pcInValid  (pcInValid),
    .pcInReady  (pcInReady),
    .bdOut      (bdOut),
    .bdOutValid (bdOutValid),
    .bdOutReady (bdOutReady)
  );

  spikeCoreChecker monitor (
    .clk         (clk),
    .reset       (reset),
    .pcIn        (pcIn),
    .pcInValid   (pcInValid),
    .pcInReady   (pcInReady),
    .bdOut       (bdOut),
    .bdOutValid  (bdOutValid),
    .bdOutReady  (bdOutReady),
    .isolated    (isolated),
    .runDone     (runDone),
    .mismatches  (mismatches),
    .otherErrors (otherErrors),
    .checked     (checked)
  );

  ////////////////////
  // Clock and watchdog

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles <= cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run did not finish within %0d cycles", cycleLimit);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic int randRange(input int n);
    return ($random(seed) & 32'h7fffffff) % n;
  endfunction

  function automatic pcWord randWord(input logic [`CORE_PC_CODE_WIDTH-1:0] code);
    pcWord w;
    w = $random(seed);
    w[`CORE_PC_WIDTH-1 -: `CORE_PC_CODE_WIDTH] = code;
    return w;
  endfunction

  // Drawn mid cycle, about 70 percent high
  initial begin
    bdOutReady = 1'b0;
    forever begin
      @(negedge clk);
      nextReady = holdReady || (randRange(10) < 7);
      @(posedge clk);
      #2 bdOutReady = nextReady;
    end
  end

  ////////////////////
  // Stimulus

  // Called 2 ns after an edge, returns 2 ns after the transfer edge
  task automatic sendWord(input pcWord word);
    pcIn = word;
    pcInValid = 1'b1;
    @(negedge clk);
    while (!pcInReady) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    pcInValid = 1'b0;
  endtask

  task automatic confWrite(input int addr, input int value);
    sendWord({codeConfWrite, confAddr'(addr), confValue'(value)});
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    int choice;
    reset = 1'b1;
    pcIn = '0;
    pcInValid = 1'b0;
    holdReady = 1'b1;
    isolated = 1'b0;
    runDone = 1'b0;
    repeat (3) @(posedge clk);
    #2 reset = 1'b0;
    // Lone passthrough word, output always ready
    idleCycles(2);
    isolated = 1'b1;
    sendWord(randWord(codePass));
    idleCycles(6);
    isolated = 1'b0;
    holdReady = 1'b0;
    // Distinct nonzero tags, never rewritten
    for (int g = 0; g < `CORE_NUM_GENS; g++) begin
      confWrite(`CORE_ADDR_TAG + g, 'h400 | (randRange(256) << 2) | g);
      confWrite(`CORE_ADDR_PERIOD + g, 1 + randRange(6));
    end
    confWrite(`CORE_ADDR_UNIT, 3 + randRange(6));
    confWrite(`CORE_ADDR_ENABLE, 1 + randRange(15));
    for (int i = 0; i < numWords; i++) begin
      choice = randRange(10);
      if (choice < 5) begin
        sendWord(randWord(codePass));
      end else if (choice < 7) begin
        // Junk codes 3 to 255
        sendWord(randWord(8'(3 + randRange(253))));
      end else if (choice == 7) begin
        confWrite(`CORE_ADDR_PERIOD + randRange(`CORE_NUM_GENS), 1 + randRange(6));
      end else if (choice == 8 && randRange(2) == 0) begin
        confWrite(`CORE_ADDR_UNIT, 3 + randRange(6));
      end else if (choice == 8) begin
        confWrite(`CORE_ADDR_ENABLE, randRange(16));
      end else begin
        // Unmapped register
        confWrite(10 + randRange(200), randRange(65536));
      end
      idleCycles(randRange(3));
    end
    confWrite(`CORE_ADDR_ENABLE, 0);
    idleCycles(drainCycles);
    runDone = 1'b1;
    wait (checked);
    $display("errors: %0d mismatches, %0d other", mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: spikeCore.f
+incdir+rtl
rtl/pcWordPkg.sv
rtl/bdWordPkg.sv
rtl/coreIfs.sv
rtl/pcParser.sv
rtl/spikeGenArray.sv
rtl/bdTagMerge.sv
rtl/spikeCore.sv
dv/spikeCoreChecker.sv
dv/spikeCoreTb.sv

// File: Bender.yml
package:
  name: spikeCore

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pcWordPkg.sv
      - rtl/bdWordPkg.sv
      - rtl/coreIfs.sv
      - rtl/pcParser.sv
      - rtl/spikeGenArray.sv
      - rtl/bdTagMerge.sv
      - rtl/spikeCore.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/spikeCoreChecker.sv
      - dv/spikeCoreTb.sv
